// File: common/splash_pkg.sv
package splash_pkg;

	// --------------------------------------------------
	// parameter defaults
	// --------------------------------------------------
	localparam int ADDR_W_MAX = 15;	// 32768 pixel frame
	localparam int DEFAULT_ADDR_W = 15;
	localparam int DEFAULT_CREDITS = 4;
	localparam int DEFAULT_FLASH_PERIOD = 12_500_000;	// quarter second at 50 MHz

	// --------------------------------------------------
	// types
	// --------------------------------------------------
	typedef enum logic [1:0] {
		title = 2'd0,
		black = 2'd1,
		game_over = 2'd2,
		red = 2'd3
	} screen_kind_t;

	typedef logic [11:0] pixel_t;	// 4 bits each of r, g, b

	typedef struct packed {
		logic valid;
		screen_kind_t kind;
	} fill_req_t;

	typedef struct packed {
		logic valid;
		logic [ADDR_W_MAX-1:0] addr;	// only low ADDR_W bits used
		pixel_t pixel;
	} pix_wr_t;

	// one solid color per screen, indexed by screen_kind_t
	localparam pixel_t COLOR_TABLE [4] = '{
		12'h28c,	// title
		12'h000,	// black
		12'hff0,	// game over
		12'hf00		// red
	};

	function automatic pixel_t screen_color(input screen_kind_t kind);
		return COLOR_TABLE[kind];
	endfunction

endpackage

// File: source/flash_timer.sv
`timescale 1ns/1ps

module flash_timer #(
	parameter int FLASH_PERIOD = splash_pkg::DEFAULT_FLASH_PERIOD
) (
	input logic clk,
	input logic rst,
	input logic flash_restart,
	output logic tick
);

	localparam int CW = $clog2(FLASH_PERIOD + 1);
	localparam logic [CW-1:0] RELOAD = CW'(FLASH_PERIOD - 1);

	logic [CW-1:0] count;

	// expiry pulses unless a restart lands in the same cycle
	assign tick = (count == '0) && !flash_restart;

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			count <= RELOAD;
		else if (flash_restart || count == '0)
			count <= RELOAD;
		else
			count <= count - 1'b1;
	end

endmodule

// File: source/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer #(
	parameter int ADDR_W = splash_pkg::DEFAULT_ADDR_W,
	parameter int CREDITS = splash_pkg::DEFAULT_CREDITS
) (
	input logic clk,
	input logic rst,
	input splash_pkg::pix_wr_t pix_wr,
	output logic credit_ret,
	input logic rd_en,
	input logic [ADDR_W-1:0] rd_addr,
	output splash_pkg::pixel_t rd_pixel
);

	localparam int PW = (CREDITS > 1) ? $clog2(CREDITS) : 1;
	localparam int CW = $clog2(CREDITS + 1);

	splash_pkg::pixel_t mem [2**ADDR_W];
	splash_pkg::pix_wr_t s1_q;	// first stage of the write path
	splash_pkg::pix_wr_t fifo_q [CREDITS];
	splash_pkg::pix_wr_t head;
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic commit;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
		return (ptr == PW'(CREDITS - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign head = fifo_q[rd_ptr];
	assign commit = (count != '0) && !rd_en;	// read owns the port
	assign credit_ret = commit;

	// --------------------------------------------------
	// queue control
	// --------------------------------------------------
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			s1_q <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			s1_q <= pix_wr;
			if (s1_q.valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (commit)
				rd_ptr <= next_ptr(rd_ptr);
			case ({s1_q.valid, commit})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// --------------------------------------------------
	// storage and single memory port
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (s1_q.valid)
			fifo_q[wr_ptr] <= s1_q;
		if (rd_en)
			rd_pixel <= mem[rd_addr];
		else if (commit)
			mem[head.addr[ADDR_W-1:0]] <= head.pixel;
	end

endmodule

// File: source/screen_top.sv
`timescale 1ns/1ps

module screen_top #(
	parameter int ADDR_W = splash_pkg::DEFAULT_ADDR_W,
	parameter int CREDITS = splash_pkg::DEFAULT_CREDITS,
	parameter int FLASH_PERIOD = splash_pkg::DEFAULT_FLASH_PERIOD
) (
	input logic clk,
	input logic rst,
	input logic start_n,
	input logic is_dead,
	input logic rd_en,
	input logic [ADDR_W-1:0] rd_addr,
	output logic game_run,
	output logic busy,
	output splash_pkg::screen_kind_t screen,
	output splash_pkg::pixel_t rd_pixel
);

	splash_pkg::fill_req_t fill_req;
	splash_pkg::pix_wr_t pix_wr;
	logic fill_done;
	logic credit_ret;
	logic flash_restart;
	logic tick;

	// --------------------------------------------------
	// sequencing
	// --------------------------------------------------
	splash_ctrl splash_ctrl_inst (
		.clk(clk),
		.rst(rst),
		.start_n(start_n),
		.is_dead(is_dead),
		.tick(tick),
		.fill_done(fill_done),
		.fill_req(fill_req),
		.flash_restart(flash_restart),
		.game_run(game_run),
		.busy(busy),
		.screen(screen)
	);

	flash_timer #(
		.FLASH_PERIOD(FLASH_PERIOD)
	) flash_timer_inst (
		.clk(clk),
		.rst(rst),
		.flash_restart(flash_restart),
		.tick(tick)
	);

	// --------------------------------------------------
	// pixel path
	// --------------------------------------------------
	screen_painter #(
		.ADDR_W(ADDR_W),
		.CREDITS(CREDITS)
	) screen_painter_inst (
		.clk(clk),
		.rst(rst),
		.fill_req(fill_req),
		.credit_ret(credit_ret),
		.pix_wr(pix_wr),
		.fill_done(fill_done)
	);

	frame_buffer #(
		.ADDR_W(ADDR_W),
		.CREDITS(CREDITS)
	) frame_buffer_inst (
		.clk(clk),
		.rst(rst),
		.pix_wr(pix_wr),
		.credit_ret(credit_ret),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_pixel(rd_pixel)
	);

endmodule

// File: splash/screen_painter.sv
`timescale 1ns/1ps

module screen_painter #(
	parameter int ADDR_W = splash_pkg::DEFAULT_ADDR_W,
	parameter int CREDITS = splash_pkg::DEFAULT_CREDITS
) (
	input logic clk,
	input logic rst,
	input splash_pkg::fill_req_t fill_req,
	input logic credit_ret,
	output splash_pkg::pix_wr_t pix_wr,
	output logic fill_done
);

	localparam int CW = $clog2(CREDITS + 1);
	localparam logic [ADDR_W-1:0] LAST_ADDR = '1;

	logic active;
	splash_pkg::screen_kind_t kind;
	logic [ADDR_W-1:0] addr;
	logic [CW-1:0] credits;
	logic issue;

	assign issue = active && (credits != '0);	// no write without a credit

	// --------------------------------------------------
	// write output
	// --------------------------------------------------
	always_comb
	begin
		pix_wr = '0;
		pix_wr.valid = issue;
		pix_wr.addr[ADDR_W-1:0] = addr;
		pix_wr.pixel = splash_pkg::screen_color(kind);
	end

	// --------------------------------------------------
	// address walk
	// --------------------------------------------------
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			active <= 1'b0;
			kind <= splash_pkg::title;
			addr <= '0;
			fill_done <= 1'b0;
		end
		else
		begin
			fill_done <= issue && (addr == LAST_ADDR);
			if (fill_req.valid)
			begin
				active <= 1'b1;
				kind <= fill_req.kind;
				addr <= '0;
			end
			else if (issue)
			begin
				addr <= addr + 1'b1;
				if (addr == LAST_ADDR)
					active <= 1'b0;	// frame complete
			end
		end
	end

	// --------------------------------------------------
	// credit counter
	// --------------------------------------------------
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			credits <= CW'(CREDITS);
		else
		begin
			case ({issue, credit_ret})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;	// both or neither
			endcase
		end
	end

endmodule

// File: splash/splash_ctrl.sv
`timescale 1ns/1ps

module splash_ctrl (
	input logic clk,
	input logic rst,
	input logic start_n,
	input logic is_dead,
	input logic tick,
	input logic fill_done,
	output splash_pkg::fill_req_t fill_req,
	output logic flash_restart,
	output logic game_run,
	output logic busy,
	output splash_pkg::screen_kind_t screen
);

	typedef enum logic [3:0] {
		st_boot,
		st_draw_title,
		st_title,
		st_draw_black,
		st_run,
		st_draw_over,
		st_over,
		st_draw_red,
		st_red,
		st_restart
	} state_t;

	state_t state;
	state_t next_state;
	splash_pkg::screen_kind_t next_kind;
	logic draw_entry;
	logic tick_pend;
	logic tick_seen;
	logic take_tick;

	assign tick_seen = tick | tick_pend;	// ticks during a fill are kept
	assign take_tick = (state inside {st_over, st_red}) && !start_n && tick_seen;

	// --------------------------------------------------
	// next state
	// --------------------------------------------------
	always_comb
	begin
		next_state = state;
		case (state)
			st_boot: next_state = st_draw_title;
			st_draw_title: if (fill_done) next_state = st_title;
			st_title: if (!start_n) next_state = st_draw_black;
			st_draw_black: if (fill_done) next_state = st_run;
			st_run: if (is_dead) next_state = st_draw_over;
			st_draw_over: if (fill_done) next_state = st_over;
			st_over:
			begin
				if (start_n)
					next_state = st_restart;	// button released
				else if (tick_seen)
					next_state = st_draw_red;
			end
			st_draw_red: if (fill_done) next_state = st_red;
			st_red:
			begin
				if (start_n)
					next_state = st_restart;
				else if (tick_seen)
					next_state = st_draw_over;
			end
			st_restart: if (!start_n) next_state = st_draw_title;
			default: next_state = st_boot;
		endcase
	end

	assign draw_entry = (next_state != state) &&
		(next_state inside {st_draw_title, st_draw_black, st_draw_over, st_draw_red});

	always_comb
	begin
		case (next_state)
			st_draw_black: next_kind = splash_pkg::black;
			st_draw_over: next_kind = splash_pkg::game_over;
			st_draw_red: next_kind = splash_pkg::red;
			default: next_kind = splash_pkg::title;
		endcase
	end

	// --------------------------------------------------
	// registers
	// --------------------------------------------------
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			state <= st_boot;
			fill_req <= '0;
			flash_restart <= 1'b0;
			tick_pend <= 1'b0;
			screen <= splash_pkg::title;
		end
		else
		begin
			state <= next_state;
			fill_req.valid <= draw_entry;	// one cycle per fill
			fill_req.kind <= next_kind;
			if (draw_entry)
				screen <= next_kind;
			flash_restart <= (state == st_run) && is_dead;	// flashing rhythm starts here
			if (flash_restart)
				tick_pend <= 1'b0;
			else if (take_tick)
				tick_pend <= 1'b0;
			else if (tick)
				tick_pend <= 1'b1;
		end
	end

	assign game_run = (state == st_run);
	assign busy = state inside {st_draw_title, st_draw_black, st_draw_over, st_draw_red};

endmodule

// File: verification/screen_props.sv
`timescale 1ns/1ps

module screen_props #(
	parameter int CREDITS = splash_pkg::DEFAULT_CREDITS
) (
	input logic clk,
	input logic rst,
	input splash_pkg::fill_req_t fill_req,
	input splash_pkg::pix_wr_t pix_wr,
	input logic credit_ret,
	input logic active
);

	int outstanding;	// writes issued and not yet committed
	int failures = 0;

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
			outstanding <= 0;
		else
			outstanding <= outstanding + int'(pix_wr.valid) - int'(credit_ret);
	end

	// credits left are CREDITS minus the writes still in flight
	no_write_without_credit: assert property (@(posedge clk) disable iff (!rst)
		pix_wr.valid |-> outstanding < CREDITS)
	else
	begin
		failures++;
		$error("painter issued a write with no credit left");
	end

	credit_within_outstanding: assert property (@(posedge clk) disable iff (!rst)
		credit_ret |-> outstanding > 0)
	else
	begin
		failures++;
		$error("frame buffer returned a credit with no write outstanding");
	end

	outstanding_bounded: assert property (@(posedge clk) disable iff (!rst)
		outstanding <= CREDITS)
	else
	begin
		failures++;
		$error("more writes in flight than credits");
	end

	no_fill_while_busy: assert property (@(posedge clk) disable iff (!rst)
		fill_req.valid |-> !active)
	else
	begin
		failures++;
		$error("new fill order arrived while a fill was running");
	end

endmodule

// credit_ret seen here is the frame buffer's output
bind screen_painter screen_props #(
	.CREDITS(CREDITS)
) screen_props_inst (
	.clk(clk),
	.rst(rst),
	.fill_req(fill_req),
	.pix_wr(pix_wr),
	.credit_ret(credit_ret),
	.active(active)
);

// File: verification/screen_tb.sv
`timescale 1ns/1ps

module screen_tb;

	localparam int ADDR_W = 6;
	localparam int CREDITS = 4;
	localparam int FLASH_PERIOD = 200;
	localparam int DEPTH = 2 ** ADDR_W;
	localparam int FILL_LIMIT = 8 * DEPTH;

	logic clk;
	logic rst;
	logic start_n;
	logic is_dead;
	logic rd_en;
	logic [ADDR_W-1:0] rd_addr;
	logic game_run;
	logic busy;
	splash_pkg::screen_kind_t screen;
	splash_pkg::pixel_t rd_pixel;

	int pixel_errors = 0;
	int screen_errors = 0;
	int flag_errors = 0;
	int timeout_errors = 0;
	int assert_errors;
	int seed;

	screen_top #(
		.ADDR_W(ADDR_W),
		.CREDITS(CREDITS),
		.FLASH_PERIOD(FLASH_PERIOD)
	) screen_top_inst (
		.clk(clk),
		.rst(rst),
		.start_n(start_n),
		.is_dead(is_dead),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.game_run(game_run),
		.busy(busy),
		.screen(screen),
		.rd_pixel(rd_pixel)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic compare_pixel(input string name, input splash_pkg::pixel_t exp,
		input splash_pkg::pixel_t act);
		if (act !== exp)
		begin
			pixel_errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic compare_screen(input string name, input splash_pkg::screen_kind_t exp,
		input splash_pkg::screen_kind_t act);
		if (act !== exp)
		begin
			screen_errors++;
			$display("error %s: expected %s, actual %s (%b)", name, exp.name(), act.name(), act);
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			flag_errors++;
			$display("error %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic next_cycle();
		@(posedge clk);
		#1;	// inputs change just after the edge
	endtask

	task automatic wait_busy(input string name, input logic level, input int limit);
		int n;
		n = 0;
		while (busy !== level && n < limit)
		begin
			next_cycle();
			n++;
		end
		if (busy !== level)
		begin
			timeout_errors++;
			$display("timeout in %s: busy did not go %s within %0d cycles",
				name, level ? "high" : "low", limit);
		end
	endtask

	// writes still queued in the frame buffer when fill_done comes
	task automatic drain_writes();
		rd_en = 1'b0;
		repeat (CREDITS + 2)
			next_cycle();
	endtask

	task automatic read_frame(input string name, input splash_pkg::pixel_t exp);
		int a;
		rd_en = 1'b1;
		rd_addr = '0;
		for (a = 0; a < DEPTH; a++)
		begin
			next_cycle();	// rd_pixel now holds address a
			compare_pixel($sformatf("%s addr %0d", name, a), exp, rd_pixel);
			if (a + 1 < DEPTH)
				rd_addr = ADDR_W'(a + 1);
			else
				rd_en = 1'b0;
		end
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic check_title_after_reset();
		wait_busy("title", 1'b1, 10);
		wait_busy("title", 1'b0, FILL_LIMIT);
		compare_screen("title", splash_pkg::title, screen);
		compare_flag("title game_run", 1'b0, game_run);
		drain_writes();
		read_frame("title", splash_pkg::screen_color(splash_pkg::title));
	endtask

	task automatic start_game();
		start_n = 1'b0;	// held through the game over tests
		wait_busy("start", 1'b1, 10);
		compare_flag("start game_run while drawing", 1'b0, game_run);
		wait_busy("start", 1'b0, FILL_LIMIT);
		compare_screen("start", splash_pkg::black, screen);
		compare_flag("start game_run", 1'b1, game_run);
		drain_writes();
		read_frame("start", splash_pkg::screen_color(splash_pkg::black));
	endtask

	task automatic die_to_game_over();
		is_dead = 1'b1;
		wait_busy("death", 1'b1, 10);
		is_dead = 1'b0;
		wait_busy("death", 1'b0, FILL_LIMIT);
		compare_screen("death", splash_pkg::game_over, screen);
		compare_flag("death game_run", 1'b0, game_run);
		drain_writes();
		read_frame("death", splash_pkg::screen_color(splash_pkg::game_over));
	endtask

	task automatic flash_game_over();
		splash_pkg::screen_kind_t exp;
		int i;
		for (i = 0; i < 2; i++)
		begin
			exp = (i % 2 == 0) ? splash_pkg::red : splash_pkg::game_over;
			wait_busy("flash", 1'b1, 3 * FLASH_PERIOD);	// next tick
			wait_busy("flash", 1'b0, FILL_LIMIT);
			compare_screen($sformatf("flash %0d", i), exp, screen);
			drain_writes();
			read_frame($sformatf("flash %0d", i), splash_pkg::screen_color(exp));
		end
	endtask

	task automatic restart_to_title();
		start_n = 1'b1;	// release in game over
		repeat (3)
			next_cycle();
		compare_flag("restart busy", 1'b0, busy);
		start_n = 1'b0;
		wait_busy("restart", 1'b1, 10);
		start_n = 1'b1;	// short press, stay on title
		wait_busy("restart", 1'b0, FILL_LIMIT);
		compare_screen("restart", splash_pkg::title, screen);
		compare_flag("restart game_run", 1'b0, game_run);
		drain_writes();
		read_frame("restart", splash_pkg::screen_color(splash_pkg::title));
	endtask

	task automatic fill_under_backpressure();
		int n;
		int r;
		start_n = 1'b0;
		wait_busy("backpressure", 1'b1, 10);
		start_n = 1'b1;
		n = 0;
		while (busy === 1'b1 && n < 40 * DEPTH)
		begin
			r = $random(seed);
			rd_en = (r[2:0] < 3'd5);	// reads win most cycles
			rd_addr = r[8 +: ADDR_W];
			next_cycle();
			n++;
		end
		rd_en = 1'b0;
		if (busy !== 1'b0)
		begin
			timeout_errors++;
			$display("timeout in backpressure: fill did not finish under random reads");
		end
		compare_screen("backpressure", splash_pkg::black, screen);
		compare_flag("backpressure game_run", 1'b1, game_run);
		drain_writes();
		read_frame("backpressure", splash_pkg::screen_color(splash_pkg::black));
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		seed = 32'h5a692f4b;
		rst = 1'b0;
		start_n = 1'b1;
		is_dead = 1'b0;
		rd_en = 1'b0;
		rd_addr = '0;
		repeat (4)
			next_cycle();
		rst = 1'b1;

		check_title_after_reset();
		start_game();
		die_to_game_over();
		flash_game_over();
		restart_to_title();
		fill_under_backpressure();

		assert_errors = screen_top_inst.screen_painter_inst.screen_props_inst.failures;
		$display("errors: pixel %0d, screen %0d, flag %0d, timeout %0d, assertion %0d",
			pixel_errors, screen_errors, flag_errors, timeout_errors, assert_errors);
		if (pixel_errors + screen_errors + flag_errors + timeout_errors + assert_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: vlog.f
common/splash_pkg.sv
source/flash_timer.sv
source/frame_buffer.sv
splash/screen_painter.sv
splash/splash_ctrl.sv
source/screen_top.sv
verification/screen_props.sv
verification/screen_tb.sv
